// File: files.f
+incdir+hdl
hdl/cnl_data_pkg.sv
hdl/cnl_job_pkg.sv
hdl/fifo_fwft.sv
hdl/weight_bram_arb.sv
hdl/conv_quad.sv
hdl/cnl_job_ctrl.sv
hdl/cnn_layer_accel_top.sv
tests/cnl_tb.sv

// File: hdl/cnl_data_pkg.sv
`default_nettype none
`include "cnl_params.svh"

package cnl_data_pkg;

    typedef logic signed [`CNL_PIXEL_WIDTH-1:0] pixel_t;
    typedef logic signed [`CNL_WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [`CNL_PSUM_WIDTH-1:0] psum_t;
    typedef logic [$clog2(`CNL_NUM_KERNELS)-1:0] kernel_idx_t;

    // tap 0 sits in the low bits
    typedef struct packed {
        weight_t [`CNL_NUM_TAPS-1:0] tap;
    } kernel_t;

    typedef struct packed {
        pixel_t [`CNL_NUM_TAPS-1:0] tap;
    } slice_t;

    // one depth slice per quad, quad 0 in the low bits
    typedef struct packed {
        slice_t [`CNL_NUM_QUADS-1:0] quad;
    } window_t;

endpackage

`default_nettype wire

// File: hdl/cnl_job_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnl_params.svh"

module cnl_job_ctrl (
    input  wire logic                                        clk_core,
    input  wire logic                                        rst,

    input  wire logic                                        job_valid,
    output logic                                             job_ready,
    input  wire cnl_job_pkg::job_t                           job,

    output logic                                             job_start,
    output cnl_data_pkg::kernel_idx_t [`CNL_NUM_QUADS-1:0]   kernel_idx,

    input  wire logic                                        pix_valid,
    output logic                                             pix_ready,
    input  wire cnl_data_pkg::window_t                       pix,

    output logic [`CNL_NUM_QUADS-1:0]                        slice_valid,
    input  wire logic [`CNL_NUM_QUADS-1:0]                   slice_ready,
    output cnl_data_pkg::slice_t [`CNL_NUM_QUADS-1:0]        slice,

    input  wire logic                                        fifo_valid,
    output logic                                             fifo_ready,
    input  wire cnl_data_pkg::psum_t                         fifo_psum,

    output logic                                             res_valid,
    input  wire logic                                        res_ready,
    output cnl_data_pkg::psum_t                              res,

    output logic                                             job_done
);

    // one bit more than num_windows, so 256 fits
    localparam int CNT_W = 9;

    cnl_data_pkg::kernel_idx_t [`CNL_NUM_QUADS-1:0] kidx_q;
    logic                                           active;
    logic [CNT_W-1:0]                               win_left;
    logic [CNT_W-1:0]                               res_left;
    logic [CNT_W-1:0]                               job_len;
    logic                                           job_fire;
    logic                                           pix_fire;
    logic                                           res_fire;

    assign job_ready = !active;
    assign job_fire  = job_valid && job_ready;
    assign job_len   = (job.num_windows == '0) ? CNT_W'(256) : CNT_W'(job.num_windows);

    assign kernel_idx = kidx_q;

    // hold windows off while the quads still see job_start
    assign pix_ready   = active && !job_start && (win_left != '0) && (&slice_ready);
    assign pix_fire    = pix_valid && pix_ready;
    assign slice_valid = {`CNL_NUM_QUADS{pix_fire}};
    assign slice       = pix.quad;

    // result path
    assign res_valid  = active && fifo_valid;
    assign fifo_ready = active && res_ready;
    assign res        = fifo_psum;
    assign res_fire   = res_valid && res_ready;

    always_ff @(posedge clk_core) begin
        if (job_fire) begin
            kidx_q <= job.kidx;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            active    <= 1'b0;
            job_start <= 1'b0;
            job_done  <= 1'b0;
            win_left  <= '0;
            res_left  <= '0;
        end else begin
            job_start <= job_fire;
            job_done  <= 1'b0;
            if (job_fire) begin
                active   <= 1'b1;
                win_left <= job_len;
                res_left <= job_len;
            end
            if (pix_fire) begin
                win_left <= win_left - 1'b1;
            end
            if (res_fire) begin
                res_left <= res_left - 1'b1;
                // last result of the job
                if (res_left == CNT_W'(1)) begin
                    active   <= 1'b0;
                    job_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/cnl_job_pkg.sv
`default_nettype none
`include "cnl_params.svh"

package cnl_job_pkg;

    // num_windows of 0 stands for 256 windows
    typedef struct packed {
        cnl_data_pkg::kernel_idx_t [`CNL_NUM_QUADS-1:0] kidx;
        logic [7:0]                                     num_windows;
    } job_t;

    // one whole kernel per write
    typedef struct packed {
        cnl_data_pkg::kernel_idx_t addr;
        cnl_data_pkg::kernel_t     data;
    } weight_wr_t;

endpackage

`default_nettype wire

// File: hdl/cnl_params.svh
`ifndef CNL_PARAMS_SVH
`define CNL_PARAMS_SVH

// data widths, all signed
`define CNL_PIXEL_WIDTH     8
`define CNL_WEIGHT_WIDTH    8
`define CNL_PSUM_WIDTH      20

// 3x3 kernel
`define CNL_NUM_TAPS        9

// quads in the cascade
`define CNL_NUM_QUADS       2

// kernel memory depth
`define CNL_NUM_KERNELS     16

// fifo depths
`define CNL_CASCADE_DEPTH   4
`define CNL_RESULT_DEPTH    4

`endif

// File: hdl/cnn_layer_accel_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnl_params.svh"

module cnn_layer_accel_top (
    input  wire logic                    clk_core,
    input  wire logic                    rst,

    input  wire logic                    job_valid,
    output logic                         job_ready,
    input  wire cnl_job_pkg::job_t       job,

    input  wire logic                    wr_valid,
    output logic                         wr_ready,
    input  wire cnl_job_pkg::weight_wr_t wr,

    input  wire logic                    pix_valid,
    output logic                         pix_ready,
    input  wire cnl_data_pkg::window_t   pix,

    output logic                         res_valid,
    input  wire logic                    res_ready,
    output cnl_data_pkg::psum_t          res,

    output logic                         job_done
);

    localparam int NQ = `CNL_NUM_QUADS;

    logic                                  job_start;
    cnl_data_pkg::kernel_idx_t [NQ-1:0]    kernel_idx;
    logic [NQ-1:0]                         slice_valid;
    wire logic [NQ-1:0]                    slice_ready;
    cnl_data_pkg::slice_t [NQ-1:0]         slice;

    // kernel fetch, one lane per quad
    wire logic [NQ-1:0]                    rd_req;
    wire cnl_data_pkg::kernel_idx_t [NQ-1:0] rd_idx;
    logic [NQ-1:0]                         rd_grant;
    logic [NQ-1:0]                         rd_valid;
    cnl_data_pkg::kernel_t                 rd_kernel;

    // quad 0 into the cascade fifo, fifo into quad 1
    logic                                  casc_wr_valid;
    logic                                  casc_wr_ready;
    cnl_data_pkg::psum_t                   casc_wr_data;
    logic                                  casc_rd_valid;
    logic                                  casc_rd_ready;
    cnl_data_pkg::psum_t                   casc_rd_data;

    // quad 1 into the result fifo, fifo into the job controller
    logic                                  q1_valid;
    logic                                  q1_ready;
    cnl_data_pkg::psum_t                   q1_psum;
    logic                                  rfifo_valid;
    logic                                  rfifo_ready;
    cnl_data_pkg::psum_t                   rfifo_psum;

    cnl_job_ctrl cnl_job_ctrl_inst (
        .clk_core    ( clk_core    ),
        .rst         ( rst         ),
        .job_valid   ( job_valid   ),
        .job_ready   ( job_ready   ),
        .job         ( job         ),
        .job_start   ( job_start   ),
        .kernel_idx  ( kernel_idx  ),
        .pix_valid   ( pix_valid   ),
        .pix_ready   ( pix_ready   ),
        .pix         ( pix         ),
        .slice_valid ( slice_valid ),
        .slice_ready ( slice_ready ),
        .slice       ( slice       ),
        .fifo_valid  ( rfifo_valid ),
        .fifo_ready  ( rfifo_ready ),
        .fifo_psum   ( rfifo_psum  ),
        .res_valid   ( res_valid   ),
        .res_ready   ( res_ready   ),
        .res         ( res         ),
        .job_done    ( job_done    )
    );

    weight_bram_arb weight_bram_arb_inst (
        .clk_core  ( clk_core  ),
        .rst       ( rst       ),
        .wr_valid  ( wr_valid  ),
        .wr_ready  ( wr_ready  ),
        .wr        ( wr        ),
        .rd_req    ( rd_req    ),
        .rd_idx    ( rd_idx    ),
        .rd_grant  ( rd_grant  ),
        .rd_valid  ( rd_valid  ),
        .rd_kernel ( rd_kernel )
    );

    ////////////////////////////////////////////////////////////
    // quad cascade
    ////////////////////////////////////////////////////////////

    conv_quad #(
        .MASTER ( 1 )
    ) conv_quad_0_inst (
        .clk_core    ( clk_core       ),
        .rst         ( rst            ),
        .job_start   ( job_start      ),
        .kernel_idx  ( kernel_idx[0]  ),
        .rd_req      ( rd_req[0]      ),
        .rd_idx      ( rd_idx[0]      ),
        .rd_grant    ( rd_grant[0]    ),
        .rd_valid    ( rd_valid[0]    ),
        .rd_kernel   ( rd_kernel      ),
        .slice_valid ( slice_valid[0] ),
        .slice_ready ( slice_ready[0] ),
        .slice       ( slice[0]       ),
        .casc_valid  ( 1'b0           ),
        .casc_ready  (                ),
        .casc        ( '0             ),
        .out_valid   ( casc_wr_valid  ),
        .out_ready   ( casc_wr_ready  ),
        .out_psum    ( casc_wr_data   )
    );

    fifo_fwft #(
        .payload_t ( cnl_data_pkg::psum_t ),
        .DEPTH     ( `CNL_CASCADE_DEPTH   )
    ) casc_fifo_inst (
        .clk_core ( clk_core      ),
        .rst      ( rst           ),
        .wr_valid ( casc_wr_valid ),
        .wr_ready ( casc_wr_ready ),
        .wr_data  ( casc_wr_data  ),
        .rd_valid ( casc_rd_valid ),
        .rd_ready ( casc_rd_ready ),
        .rd_data  ( casc_rd_data  )
    );

    conv_quad #(
        .MASTER ( 0 )
    ) conv_quad_1_inst (
        .clk_core    ( clk_core       ),
        .rst         ( rst            ),
        .job_start   ( job_start      ),
        .kernel_idx  ( kernel_idx[1]  ),
        .rd_req      ( rd_req[1]      ),
        .rd_idx      ( rd_idx[1]      ),
        .rd_grant    ( rd_grant[1]    ),
        .rd_valid    ( rd_valid[1]    ),
        .rd_kernel   ( rd_kernel      ),
        .slice_valid ( slice_valid[1] ),
        .slice_ready ( slice_ready[1] ),
        .slice       ( slice[1]       ),
        .casc_valid  ( casc_rd_valid  ),
        .casc_ready  ( casc_rd_ready  ),
        .casc        ( casc_rd_data   ),
        .out_valid   ( q1_valid       ),
        .out_ready   ( q1_ready       ),
        .out_psum    ( q1_psum        )
    );

    fifo_fwft #(
        .payload_t ( cnl_data_pkg::psum_t ),
        .DEPTH     ( `CNL_RESULT_DEPTH    )
    ) res_fifo_inst (
        .clk_core ( clk_core    ),
        .rst      ( rst         ),
        .wr_valid ( q1_valid    ),
        .wr_ready ( q1_ready    ),
        .wr_data  ( q1_psum     ),
        .rd_valid ( rfifo_valid ),
        .rd_ready ( rfifo_ready ),
        .rd_data  ( rfifo_psum  )
    );

endmodule

`default_nettype wire

// File: hdl/conv_quad.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnl_params.svh"

module conv_quad #(
    parameter int MASTER = 1
) (
    input  wire logic                      clk_core,
    input  wire logic                      rst,

    input  wire logic                      job_start,
    input  wire cnl_data_pkg::kernel_idx_t kernel_idx,

    output logic                           rd_req,
    output cnl_data_pkg::kernel_idx_t      rd_idx,
    input  wire logic                      rd_grant,
    input  wire logic                      rd_valid,
    input  wire cnl_data_pkg::kernel_t     rd_kernel,

    input  wire logic                      slice_valid,
    output logic                           slice_ready,
    input  wire cnl_data_pkg::slice_t      slice,

    input  wire logic                      casc_valid,
    output logic                           casc_ready,
    input  wire cnl_data_pkg::psum_t       casc,

    output logic                           out_valid,
    input  wire logic                      out_ready,
    output cnl_data_pkg::psum_t            out_psum
);

    localparam int PROD_W = `CNL_PIXEL_WIDTH + `CNL_WEIGHT_WIDTH;

    cnl_data_pkg::kernel_t    kernel_q;
    logic                     kern_ok;
    logic                     s1_valid;
    logic signed [PROD_W-1:0] s1_prod [`CNL_NUM_TAPS];
    logic                     s1_ready;
    logic                     s1_load;
    logic                     s2_ready;
    logic                     s2_load;
    logic                     casc_ok;
    cnl_data_pkg::psum_t      sum_c;

    ////////////////////////////////////////////////////////////
    // kernel fetch
    ////////////////////////////////////////////////////////////

    // index is held by the job controller for the whole job
    assign rd_idx = kernel_idx;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            rd_req  <= 1'b0;
            kern_ok <= 1'b0;
        end else if (job_start) begin
            rd_req  <= 1'b1;
            kern_ok <= 1'b0;
        end else begin
            if (rd_grant) begin
                rd_req <= 1'b0;
            end
            if (rd_valid) begin
                kern_ok <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (rd_valid) begin
            kernel_q <= rd_kernel;
        end
    end

    ////////////////////////////////////////////////////////////
    // two-stage multiply-accumulate
    ////////////////////////////////////////////////////////////

    // the master quad has no partial sum to wait for
    assign casc_ok     = (MASTER != 0) || casc_valid;
    assign s2_ready    = !out_valid || out_ready;
    assign s2_load     = s1_valid && casc_ok && s2_ready;
    assign s1_ready    = !s1_valid || s2_load;
    assign slice_ready = kern_ok && s1_ready;
    assign s1_load     = slice_valid && slice_ready;
    assign casc_ready  = (MASTER == 0) ? s2_load : 1'b0;

    // adder tree of the nine products plus cascade input
    always_comb begin
        sum_c = (MASTER != 0) ? '0 : casc;
        for (int t = 0; t < `CNL_NUM_TAPS; t++) begin
            sum_c = sum_c + cnl_data_pkg::psum_t'(s1_prod[t]);
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= s1_load;
            end
            if (s2_ready) begin
                out_valid <= s1_valid && casc_ok;
            end
        end
    end

    always_ff @(posedge clk_core) begin
        if (s1_load) begin
            for (int t = 0; t < `CNL_NUM_TAPS; t++) begin
                s1_prod[t] <= slice.tap[t] * kernel_q.tap[t];
            end
        end
        if (s2_load) begin
            out_psum <= sum_c;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fifo_fwft.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_fwft #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk_core,
    input  wire logic     rst,

    input  wire logic     wr_valid,
    output logic          wr_ready,
    input  wire payload_t wr_data,

    output logic          rd_valid,
    input  wire logic     rd_ready,
    output payload_t      rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    // head word always on the output
    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_ff @(posedge clk_core) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/weight_bram_arb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnl_params.svh"

module weight_bram_arb (
    input  wire logic                                        clk_core,
    input  wire logic                                        rst,

    input  wire logic                                        wr_valid,
    output logic                                             wr_ready,
    input  wire cnl_job_pkg::weight_wr_t                     wr,

    input  wire logic [`CNL_NUM_QUADS-1:0]                   rd_req,
    input  wire cnl_data_pkg::kernel_idx_t [`CNL_NUM_QUADS-1:0] rd_idx,
    output logic [`CNL_NUM_QUADS-1:0]                        rd_grant,
    output logic [`CNL_NUM_QUADS-1:0]                        rd_valid,
    output cnl_data_pkg::kernel_t                            rd_kernel
);

    localparam int NQ = `CNL_NUM_QUADS;
    localparam int QW = (NQ > 1) ? $clog2(NQ) : 1;

    cnl_data_pkg::kernel_t mem [`CNL_NUM_KERNELS];

    logic [QW-1:0] last_q;
    logic [QW-1:0] gnt_idx;
    logic [QW-1:0] cand;
    logic          gnt_any;
    logic          wr_fire;

    // writes are never refused
    assign wr_ready = 1'b1;
    assign wr_fire  = wr_valid && wr_ready;

    ////////////////////////////////////////////////////////////
    // round-robin grant, starting after the last winner
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_grant = '0;
        gnt_idx  = last_q;
        gnt_any  = 1'b0;
        cand     = last_q;
        for (int k = 1; k <= NQ; k++) begin
            cand = QW'((int'(last_q) + k) % NQ);
            // a write in this cycle blocks every grant
            if (!gnt_any && !wr_fire && rd_req[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = cand;
            end
        end
        if (gnt_any) begin
            rd_grant[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            rd_valid <= '0;
            // quad 0 wins the first tie
            last_q   <= QW'(NQ - 1);
        end else begin
            rd_valid <= rd_grant;
            if (gnt_any) begin
                last_q <= gnt_idx;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // kernel memory
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (wr_fire) begin
            mem[wr.addr] <= wr.data;
        end
        if (gnt_any) begin
            rd_kernel <= mem[rd_idx[gnt_idx]];
        end
    end

endmodule

`default_nettype wire

// File: tests/cnl_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cnl_params.svh"

module cnl_tb;

    localparam int TIMEOUT_CYCLES = 5000;

    logic                      clk_core = 1'b0;
    logic                      rst;
    logic                      job_valid;
    wire logic                 job_ready;
    cnl_job_pkg::job_t         job;
    logic                      wr_valid;
    wire logic                 wr_ready;
    cnl_job_pkg::weight_wr_t   wr;
    logic                      pix_valid;
    wire logic                 pix_ready;
    cnl_data_pkg::window_t     pix;
    wire logic                 res_valid;
    logic                      res_ready = 1'b0;
    cnl_data_pkg::psum_t       res;
    wire logic                 job_done;

    // model state
    cnl_data_pkg::kernel_t     kmem [`CNL_NUM_KERNELS];
    cnl_data_pkg::psum_t       exp_q [$];
    cnl_data_pkg::kernel_idx_t cur_k0;
    cnl_data_pkg::kernel_idx_t cur_k1;
    int                        cur_len = 0;
    int                        win_count = 0;
    int                        res_count = 0;
    int                        done_count = 0;
    int                        cycle_count = 0;
    logic                      tb_active = 1'b0;
    logic                      done_due = 1'b0;
    logic                      bp_mode = 1'b0;
    logic [31:0]               rng;
    logic [31:0]               bp_rng;

    cnn_layer_accel_top cnn_layer_accel_top_inst (
        .clk_core  ( clk_core  ),
        .rst       ( rst       ),
        .job_valid ( job_valid ),
        .job_ready ( job_ready ),
        .job       ( job       ),
        .wr_valid  ( wr_valid  ),
        .wr_ready  ( wr_ready  ),
        .wr        ( wr        ),
        .pix_valid ( pix_valid ),
        .pix_ready ( pix_ready ),
        .pix       ( pix       ),
        .res_valid ( res_valid ),
        .res_ready ( res_ready ),
        .res       ( res       ),
        .job_done  ( job_done  )
    );

    always #2 clk_core = ~clk_core;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // sum over both quads and all taps truncated to the psum width
    function automatic cnl_data_pkg::psum_t expected_result(
        input cnl_data_pkg::window_t     w,
        input cnl_data_pkg::kernel_idx_t k0,
        input cnl_data_pkg::kernel_idx_t k1
    );
        cnl_data_pkg::pixel_t  p;
        cnl_data_pkg::weight_t c;
        cnl_data_pkg::kernel_t k;
        int                    acc;
        acc = 0;
        for (int q = 0; q < `CNL_NUM_QUADS; q++) begin
            k = (q == 0) ? kmem[k0] : kmem[k1];
            for (int t = 0; t < `CNL_NUM_TAPS; t++) begin
                p = w.quad[q].tap[t];
                c = k.tap[t];
                acc = acc + int'(p) * int'(c);
            end
        end
        return cnl_data_pkg::psum_t'(acc);
    endfunction

    task automatic mismatch_stop(input string name, input logic signed [31:0] exp_v,
                                 input logic signed [31:0] act_v);
        $display("CHECK FAILED at time %0t: %s expected %0d, actual %0d",
                 $time, name, exp_v, act_v);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("at time %0t: %s", $time, why);
        $display("Verification failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic write_kernel(input cnl_data_pkg::kernel_idx_t idx,
                                input cnl_data_pkg::kernel_t k);
        logic hit;
        wr_valid = 1'b1;
        wr.addr  = idx;
        wr.data  = k;
        do begin
            @(negedge clk_core);
            hit = wr_ready;
            @(posedge clk_core);
            #1;
        end while (!hit);
        wr_valid = 1'b0;
        kmem[idx] = k;
    endtask

    task automatic random_kernel(output cnl_data_pkg::kernel_t k);
        for (int t = 0; t < `CNL_NUM_TAPS; t++) begin
            rng = xorshift32(rng);
            k.tap[t] = cnl_data_pkg::weight_t'(rng[7:0]);
        end
    endtask

    task automatic submit_job(input cnl_data_pkg::kernel_idx_t k0,
                              input cnl_data_pkg::kernel_idx_t k1, input int n);
        logic hit;
        job_valid       = 1'b1;
        job.kidx[0]     = k0;
        job.kidx[1]     = k1;
        job.num_windows = 8'(n);
        do begin
            @(negedge clk_core);
            hit = job_ready;
            @(posedge clk_core);
            #1;
        end while (!hit);
        job_valid = 1'b0;
    endtask

    task automatic send_window(input cnl_data_pkg::window_t w, input logic gaps);
        logic hit;
        if (gaps) begin
            rng = xorshift32(rng);
            // idle cycle with pix_valid low
            if (rng[0]) begin
                pix_valid = 1'b0;
                @(posedge clk_core);
                #1;
            end
        end
        pix_valid = 1'b1;
        pix       = w;
        do begin
            @(negedge clk_core);
            hit = pix_ready;
            @(posedge clk_core);
            #1;
        end while (!hit);
        pix_valid = 1'b0;
    endtask

    task automatic run_job(input cnl_data_pkg::kernel_idx_t k0,
                           input cnl_data_pkg::kernel_idx_t k1,
                           input int n, input logic random_mode);
        cnl_data_pkg::window_t w;
        int                    target;
        target = done_count + 1;
        submit_job(k0, k1, n);
        for (int i = 0; i < n; i++) begin
            for (int q = 0; q < `CNL_NUM_QUADS; q++) begin
                for (int t = 0; t < `CNL_NUM_TAPS; t++) begin
                    rng = xorshift32(rng);
                    if (random_mode) begin
                        w.quad[q].tap[t] = cnl_data_pkg::pixel_t'(rng[7:0]);
                    end else begin
                        w.quad[q].tap[t] = cnl_data_pkg::pixel_t'(i * 7 + t * 3 + q * 11 - 50);
                    end
                end
            end
            send_window(w, random_mode);
        end
        while (done_count < target) begin
            @(posedge clk_core);
        end
        #1;
        assert (job_ready) else mismatch_stop("job_ready", 1, job_ready);
    endtask

    ////////////////////////////////////////////////////////////
    // handshake and result checks on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk_core) begin : monitor
        cnl_data_pkg::psum_t exp_res;
        if (!rst) begin
            // pulse only on the edge after the last result
            assert (job_done == done_due)
                else mismatch_stop("job_done", done_due, job_done);
            if (job_done) begin
                done_count++;
                assert (job_ready) else mismatch_stop("job_ready", 1, job_ready);
            end
            done_due = 1'b0;
            if (!tb_active || win_count == cur_len) begin
                assert (!pix_ready) else mismatch_stop("pix_ready", 0, pix_ready);
            end
            if (job_valid && job_ready) begin
                tb_active = 1'b1;
                cur_k0    = job.kidx[0];
                cur_k1    = job.kidx[1];
                cur_len   = (job.num_windows == 8'd0) ? 256 : int'(job.num_windows);
                win_count = 0;
                res_count = 0;
            end
            if (pix_valid && pix_ready) begin
                exp_q.push_back(expected_result(pix, cur_k0, cur_k1));
                win_count++;
            end
            if (res_valid && res_ready) begin
                assert (exp_q.size() > 0)
                    else abort_run("a result came out with no window outstanding");
                exp_res = exp_q.pop_front();
                assert (res == exp_res) else mismatch_stop("res", exp_res, res);
                res_count++;
                if (res_count == cur_len) begin
                    done_due  = 1'b1;
                    tb_active = 1'b0;
                end
            end
        end
    end

    // random result back-pressure about half the time when enabled
    always @(posedge clk_core) begin
        #1;
        bp_rng = xorshift32(bp_rng);
        res_ready = !rst && (!bp_mode || bp_rng[3]);
    end

    always @(posedge clk_core) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        cnl_data_pkg::kernel_t k;
        rst       = 1'b1;
        job_valid = 1'b0;
        job       = '0;
        wr_valid  = 1'b0;
        wr        = '0;
        pix_valid = 1'b0;
        pix       = '0;
        rng       = 32'h8009;
        bp_rng    = xorshift32(32'h8009 ^ 32'h0000_ffff);
        repeat (16) @(posedge clk_core);
        #1;
        rst = 1'b0;

        // idle state after reset
        @(negedge clk_core);
        assert (job_ready) else mismatch_stop("job_ready", 1, job_ready);
        assert (!res_valid) else mismatch_stop("res_valid", 0, res_valid);
        assert (!job_done) else mismatch_stop("job_done", 0, job_done);
        assert (!pix_ready) else mismatch_stop("pix_ready", 0, pix_ready);
        @(posedge clk_core);
        #1;

        // windows offered with no job must be refused
        pix_valid = 1'b1;
        pix       = {8{rng[17:0]}};
        repeat (8) @(posedge clk_core);
        #1;
        pix_valid = 1'b0;

        for (int i = 0; i < `CNL_NUM_KERNELS; i++) begin
            random_kernel(k);
            write_kernel(cnl_data_pkg::kernel_idx_t'(i), k);
        end

        // directed job with free flowing results
        run_job(4'd2, 4'd9, 8, 1'b0);

        // random windows with gaps and result stalls
        bp_mode = 1'b1;
        run_job(4'd4, 4'd13, 64, 1'b1);
        bp_mode = 1'b0;

        // new weights for kernel 13 and swapped quad indices
        random_kernel(k);
        write_kernel(4'd13, k);
        run_job(4'd13, 4'd4, 10, 1'b1);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
